// ==== Makefile ====
# Verilator build and run of the core testbench

.PHONY: all compile run clean

all: run

compile: obj_dir/VtbCpu

obj_dir/VtbCpu: files.f common/cpu_macros.svh common/isaPkg.sv common/pipePkg.sv \
		hdl/fetchStage.sv hdl/memWbStage.sv hdl/cpuCore.sv \
		decode/decodeStage.sv decode/regFile.sv execute/executeStage.sv \
		testbench/tbModel.svh testbench/tbCpu.sv
	verilator --binary --timing --assert -f files.f --top-module tbCpu -Mdir obj_dir

# exit status is nonzero when the testbench stops with $fatal
run: compile
	./obj_dir/VtbCpu

clean:
	rm -rf obj_dir

// ==== common/cpu_macros.svh ====
////////////////////
// core-wide constants
// word and register index widths, reset PC,
// data memory depth
////////////////////

`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define XLEN       32
`define REG_ADDR_W 5

// start of the text segment
`define RESET_PC   32'h00400000

`define DMEM_WORDS 64

`endif

// ==== common/isaPkg.sv ====
////////////////////
// ISA encoding types
// words, register indices, opcodes, ALU ops
////////////////////

`include "cpu_macros.svh"

package isaPkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;

    // only the opcodes the core implements
    typedef enum logic [6:0] {
        opLoad  = 7'b0000011,
        opStore = 7'b0100011,
        opOp    = 7'b0110011,
        opOpImm = 7'b0010011,
        opNone  = 7'b0000000
    } opcode_e;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluOp_e;

endpackage : isaPkg

// ==== common/pipePkg.sv ====
////////////////////
// pipeline control types
// result source, immediate format, forward select
////////////////////

package pipePkg;

    typedef enum logic {
        resAlu = 1'b0,
        resMem = 1'b1
    } resultSrc_e;

    typedef enum logic {
        immI = 1'b0,
        immS = 1'b1
    } immSrc_e;

    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb   = 2'b01,
        fwdMem  = 2'b10
    } forward_e;

endpackage : pipePkg

// ==== decode/decodeStage.sv ====
////////////////////
// main and ALU decoders, immediate
// extension, decode/execute register
////////////////////

`timescale 1ns/1ns

module decodeStage (
    input  logic                clk,
    input  logic                rst,
    input  isaPkg::word_t       instrD,
    input  isaPkg::word_t       rd1,
    input  isaPkg::word_t       rd2,
    output isaPkg::regAddr_t    rs1,
    output isaPkg::regAddr_t    rs2,
    output isaPkg::word_t       rd1E,
    output isaPkg::word_t       rd2E,
    output isaPkg::word_t       immE,
    output isaPkg::regAddr_t    rs1E,
    output isaPkg::regAddr_t    rs2E,
    output isaPkg::regAddr_t    rdE,
    output isaPkg::aluOp_e      aluOpE,
    output logic                aluSrcE,
    output logic                regWriteE,
    output logic                memWriteE,
    output pipePkg::resultSrc_e resultSrcE
);

    isaPkg::opcode_e     opcode;
    logic [2:0]          funct3;
    logic                funct7b5;

    logic                useFunct;  // ALU op comes from funct fields
    logic                regWriteD, memWriteD, aluSrcD;
    pipePkg::resultSrc_e resultSrcD;
    pipePkg::immSrc_e    immSrcD;
    isaPkg::aluOp_e      aluOpD;
    isaPkg::word_t       immD;

    assign opcode   = isaPkg::opcode_e'(instrD[6:0]);
    assign funct3   = instrD[14:12];
    assign funct7b5 = instrD[30];
    assign rs1      = instrD[19:15];
    assign rs2      = instrD[24:20];

    always_comb begin
        useFunct   = 1'b0;
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        aluSrcD    = 1'b0;
        resultSrcD = pipePkg::resAlu;
        immSrcD    = pipePkg::immI;
        case (opcode)
            isaPkg::opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = pipePkg::resMem;
            end
            isaPkg::opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrcD   = pipePkg::immS;
            end
            isaPkg::opOp: begin
                useFunct  = 1'b1;
                regWriteD = 1'b1;
            end
            isaPkg::opOpImm: begin
                useFunct  = 1'b1;
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            default: ;  // not implemented, no side effects
        endcase
    end

    // sub only for R-type, addi ignores bit 30
    always_comb begin
        aluOpD = isaPkg::aluAdd;
        if (useFunct) begin
            case (funct3)
                3'b000:  aluOpD = (instrD[5] && funct7b5) ? isaPkg::aluSub : isaPkg::aluAdd;
                3'b010:  aluOpD = isaPkg::aluSlt;
                3'b110:  aluOpD = isaPkg::aluOr;
                3'b111:  aluOpD = isaPkg::aluAnd;
                default: aluOpD = isaPkg::aluAdd;
            endcase
        end
    end

    assign immD = (immSrcD == pipePkg::immS) ?
                  {{20{instrD[31]}}, instrD[31:25], instrD[11:7]} :
                  {{20{instrD[31]}}, instrD[31:20]};

    always_ff @(posedge clk) begin
        if (rst) begin
            rd1E       <= '0;
            rd2E       <= '0;
            immE       <= '0;
            rs1E       <= '0;
            rs2E       <= '0;
            rdE        <= '0;
            aluOpE     <= isaPkg::aluAdd;
            aluSrcE    <= 1'b0;
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            resultSrcE <= pipePkg::resAlu;
        end else begin
            rd1E       <= rd1;
            rd2E       <= rd2;
            immE       <= immD;
            rs1E       <= rs1;
            rs2E       <= rs2;
            rdE        <= instrD[11:7];
            aluOpE     <= aluOpD;
            aluSrcE    <= aluSrcD;
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            resultSrcE <= resultSrcD;
        end
    end

endmodule : decodeStage

// ==== decode/regFile.sv ====
////////////////////
// 32 x 32 register file
////////////////////

`timescale 1ns/1ns

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  isaPkg::regAddr_t rs1,
    input  isaPkg::regAddr_t rs2,
    input  isaPkg::regAddr_t rdW,
    input  isaPkg::word_t    resultW,
    input  logic             regWriteW,
    output isaPkg::word_t    rd1,
    output isaPkg::word_t    rd2
);

    isaPkg::word_t regs [32];

    // falling edge write, so decode sees it in the same cycle
    always_ff @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWriteW && rdW != '0) begin
            regs[rdW] <= resultW;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule : regFile

// ==== execute/executeStage.sv ====
////////////////////
// forwarding, operand muxes, ALU
// and execute/memory register
////////////////////

`timescale 1ns/1ns

module executeStage (
    input  logic                clk,
    input  logic                rst,
    input  isaPkg::word_t       rd1E,
    input  isaPkg::word_t       rd2E,
    input  isaPkg::word_t       immE,
    input  isaPkg::regAddr_t    rs1E,
    input  isaPkg::regAddr_t    rs2E,
    input  isaPkg::regAddr_t    rdE,
    input  isaPkg::aluOp_e      aluOpE,
    input  logic                aluSrcE,
    input  logic                regWriteE,
    input  logic                memWriteE,
    input  pipePkg::resultSrc_e resultSrcE,
    input  isaPkg::word_t       resultW,
    input  isaPkg::regAddr_t    rdW,
    input  logic                regWriteW,
    output isaPkg::word_t       aluResultM,
    output isaPkg::word_t       writeDataM,
    output isaPkg::regAddr_t    rdM,
    output logic                regWriteM,
    output logic                memWriteM,
    output pipePkg::resultSrc_e resultSrcM
);

    pipePkg::forward_e fwdA, fwdB;
    isaPkg::word_t     srcA, srcB, writeDataE, aluResultE;

    // newest producer wins, x0 never forwarded
    function automatic pipePkg::forward_e fwdSel(isaPkg::regAddr_t rs);
        if (rs != '0 && regWriteM && rs == rdM)
            return pipePkg::fwdMem;
        else if (rs != '0 && regWriteW && rs == rdW)
            return pipePkg::fwdWb;
        else
            return pipePkg::fwdNone;
    endfunction

    function automatic isaPkg::word_t fwdMux(pipePkg::forward_e sel, isaPkg::word_t regVal);
        case (sel)
            pipePkg::fwdMem: return aluResultM;
            pipePkg::fwdWb:  return resultW;
            default:         return regVal;
        endcase
    endfunction

    assign fwdA       = fwdSel(rs1E);
    assign fwdB       = fwdSel(rs2E);
    assign srcA       = fwdMux(fwdA, rd1E);
    assign writeDataE = fwdMux(fwdB, rd2E);
    assign srcB       = aluSrcE ? immE : writeDataE;

    always_comb begin
        case (aluOpE)
            isaPkg::aluSub: aluResultE = srcA - srcB;
            isaPkg::aluAnd: aluResultE = srcA & srcB;
            isaPkg::aluOr:  aluResultE = srcA | srcB;
            isaPkg::aluSlt: aluResultE = {31'd0, $signed(srcA) < $signed(srcB)};
            default:        aluResultE = srcA + srcB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aluResultM <= '0;
            writeDataM <= '0;
            rdM        <= '0;
            regWriteM  <= 1'b0;
            memWriteM  <= 1'b0;
            resultSrcM <= pipePkg::resAlu;
        end else begin
            aluResultM <= aluResultE;
            writeDataM <= writeDataE;
            rdM        <= rdE;
            regWriteM  <= regWriteE;
            memWriteM  <= memWriteE;
            resultSrcM <= resultSrcE;
        end
    end

    // a store never writes back
    noWriteOnStore: assert property (@(posedge clk) disable iff (rst)
        !(regWriteM && memWriteM));

endmodule : executeStage

// ==== files.f ====
+incdir+common
+incdir+testbench
common/isaPkg.sv
common/pipePkg.sv
hdl/fetchStage.sv
decode/regFile.sv
decode/decodeStage.sv
execute/executeStage.sv
hdl/memWbStage.sv
hdl/cpuCore.sv
testbench/tbCpu.sv

// ==== hdl/cpuCore.sv ====
////////////////////
// five-stage RV32I subset core
// stage blocks and register file
////////////////////

`timescale 1ns/1ns

module cpuCore (
    input  logic             clk,
    input  logic             rst,
    input  isaPkg::word_t    instr,
    input  isaPkg::word_t    readData,
    output isaPkg::word_t    pc,
    output isaPkg::word_t    aluResult,
    output isaPkg::word_t    writeData,
    output logic             memWrite,
    output logic             wbEn,
    output isaPkg::regAddr_t wbRd,
    output isaPkg::word_t    wbResult
);

    isaPkg::word_t       instrD;
    isaPkg::regAddr_t    rs1, rs2;
    isaPkg::word_t       rd1, rd2;

    isaPkg::word_t       rd1E, rd2E, immE;
    isaPkg::regAddr_t    rs1E, rs2E, rdE;
    isaPkg::aluOp_e      aluOpE;
    logic                aluSrcE, regWriteE, memWriteE;
    pipePkg::resultSrc_e resultSrcE;

    isaPkg::word_t       aluResultM, writeDataM;
    isaPkg::regAddr_t    rdM;
    logic                regWriteM, memWriteM;
    pipePkg::resultSrc_e resultSrcM;

    isaPkg::word_t       resultW;
    isaPkg::regAddr_t    rdW;
    logic                regWriteW;

    fetchStage uFetch (
        .clk    (clk),
        .rst    (rst),
        .instr  (instr),
        .pc     (pc),
        .instrD (instrD)
    );

    decodeStage uDecode (
        .clk        (clk),
        .rst        (rst),
        .instrD     (instrD),
        .rd1        (rd1),
        .rd2        (rd2),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd1E       (rd1E),
        .rd2E       (rd2E),
        .immE       (immE),
        .rs1E       (rs1E),
        .rs2E       (rs2E),
        .rdE        (rdE),
        .aluOpE     (aluOpE),
        .aluSrcE    (aluSrcE),
        .regWriteE  (regWriteE),
        .memWriteE  (memWriteE),
        .resultSrcE (resultSrcE)
    );

    regFile uRegFile (
        .clk       (clk),
        .rst       (rst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rdW       (rdW),
        .resultW   (resultW),
        .regWriteW (regWriteW),
        .rd1       (rd1),
        .rd2       (rd2)
    );

    executeStage uExecute (
        .clk        (clk),
        .rst        (rst),
        .rd1E       (rd1E),
        .rd2E       (rd2E),
        .immE       (immE),
        .rs1E       (rs1E),
        .rs2E       (rs2E),
        .rdE        (rdE),
        .aluOpE     (aluOpE),
        .aluSrcE    (aluSrcE),
        .regWriteE  (regWriteE),
        .memWriteE  (memWriteE),
        .resultSrcE (resultSrcE),
        .resultW    (resultW),
        .rdW        (rdW),
        .regWriteW  (regWriteW),
        .aluResultM (aluResultM),
        .writeDataM (writeDataM),
        .rdM        (rdM),
        .regWriteM  (regWriteM),
        .memWriteM  (memWriteM),
        .resultSrcM (resultSrcM)
    );

    memWbStage uMemWb (
        .clk        (clk),
        .rst        (rst),
        .aluResultM (aluResultM),
        .readData   (readData),
        .rdM        (rdM),
        .regWriteM  (regWriteM),
        .resultSrcM (resultSrcM),
        .resultW    (resultW),
        .rdW        (rdW),
        .regWriteW  (regWriteW)
    );

    // data memory port, memory stage
    assign aluResult = aluResultM;
    assign writeData = writeDataM;
    assign memWrite  = memWriteM;

    assign wbEn     = regWriteW;
    assign wbRd     = rdW;
    assign wbResult = resultW;

endmodule : cpuCore

// ==== hdl/fetchStage.sv ====
////////////////////
// program counter and
// fetch/decode register
////////////////////

`timescale 1ns/1ns

`include "cpu_macros.svh"

module fetchStage (
    input  logic          clk,
    input  logic          rst,
    input  isaPkg::word_t instr,
    output isaPkg::word_t pc,
    output isaPkg::word_t instrD
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= `RESET_PC;
            instrD <= '0;   // decodes as not implemented
        end else begin
            pc     <= pc + 32'd4;
            instrD <= instr;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule : fetchStage

// ==== hdl/memWbStage.sv ====
////////////////////
// memory/writeback register
// and result select
////////////////////

`timescale 1ns/1ns

module memWbStage (
    input  logic                clk,
    input  logic                rst,
    input  isaPkg::word_t       aluResultM,
    input  isaPkg::word_t       readData,
    input  isaPkg::regAddr_t    rdM,
    input  logic                regWriteM,
    input  pipePkg::resultSrc_e resultSrcM,
    output isaPkg::word_t       resultW,
    output isaPkg::regAddr_t    rdW,
    output logic                regWriteW
);

    isaPkg::word_t       aluResultW, readDataW;
    pipePkg::resultSrc_e resultSrcW;

    always_ff @(posedge clk) begin
        if (rst) begin
            aluResultW <= '0;
            readDataW  <= '0;
            rdW        <= '0;
            regWriteW  <= 1'b0;
            resultSrcW <= pipePkg::resAlu;
        end else begin
            aluResultW <= aluResultM;
            readDataW  <= readData;   // load data captured in the memory cycle
            rdW        <= rdM;
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
        end
    end

    assign resultW = (resultSrcW == pipePkg::resMem) ? readDataW : aluResultW;

    resultSrcKnown: assert property (@(posedge clk) disable iff (rst)
        regWriteW |-> !$isunknown(resultSrcW));

endmodule : memWbStage

// ==== testbench/tbModel.svh ====
////////////////////
// instruction encoders, xorshift,
// data memory fill, in-order ISA model
////////////////////

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic isaPkg::word_t encR(logic [6:0] f7, isaPkg::regAddr_t rs2,
                                       isaPkg::regAddr_t rs1, logic [2:0] f3,
                                       isaPkg::regAddr_t rd);
    return {f7, rs2, rs1, f3, rd, isaPkg::opOp};
endfunction

// also used for lw, with the load opcode
function automatic isaPkg::word_t encI(logic [11:0] imm, isaPkg::regAddr_t rs1,
                                       logic [2:0] f3, isaPkg::regAddr_t rd,
                                       logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic isaPkg::word_t encS(logic [11:0] imm, isaPkg::regAddr_t rs2,
                                       isaPkg::regAddr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], isaPkg::opStore};
endfunction

function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// initial data memory word, every address bit matters
function automatic isaPkg::word_t fillWord(int unsigned k);
    isaPkg::word_t a;
    a = k;
    return (a * 32'h9e3779b9) ^ {a[15:0], ~a[15:0]};
endfunction

function automatic isaPkg::word_t aluModel(logic [2:0] f3, logic subBit,
                                           isaPkg::word_t a, isaPkg::word_t b);
    case (f3)
        3'b000:  return subBit ? a - b : a + b;
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b110:  return a | b;
        3'b111:  return a & b;
        default: return '0;
    endcase
endfunction

// runs imem in order, fills the expected write and store queues
function automatic void runModel();
    isaPkg::word_t    regs [32];
    isaPkg::word_t    mem [`DMEM_WORDS];
    isaPkg::word_t    ins, src1, src2, immI, immS, addr, res;
    isaPkg::regAddr_t rd;
    logic             writes;
    for (int k = 0; k < 32; k++)
        regs[k[4:0]] = '0;
    for (int k = 0; k < `DMEM_WORDS; k++)
        mem[k[5:0]] = fillWord(k);
    for (int k = 0; k < progCount; k++) begin
        ins    = imem[k[7:0]];
        rd     = ins[11:7];
        src1   = regs[ins[19:15]];
        src2   = regs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        writes = 1'b1;
        res    = '0;
        case (ins[6:0])
            isaPkg::opOp:    res = aluModel(ins[14:12], ins[30], src1, src2);
            isaPkg::opOpImm: res = aluModel(ins[14:12], 1'b0, src1, immI);
            isaPkg::opLoad: begin
                addr = src1 + immI;
                res  = mem[addr[7:2]];
            end
            isaPkg::opStore: begin
                addr = src1 + immS;
                mem[addr[7:2]] = src2;
                expStAddr.push_back(addr);
                expStData.push_back(src2);
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes) begin
            expWbRd.push_back(rd);    // x0 writes still show on the port
            expWbVal.push_back(res);
            if (rd != 5'd0)
                regs[rd] = res;
        end
    end
endfunction

`endif

// ==== testbench/tbCpu.sv ====
////////////////////
// testbench for cpuCore
// clock, reset, memory models, program,
// compare process, timeout
////////////////////

`timescale 1ns/1ns

`include "cpu_macros.svh"

module tbCpu;

    localparam int imemWords = 256;
    localparam int numRandom = 200;

    logic             clk = 1'b0;
    logic             rst;
    isaPkg::word_t    instr, readData, pc, aluResult, writeData, wbResult;
    logic             memWrite, wbEn;
    isaPkg::regAddr_t wbRd;

    isaPkg::word_t    imem [imemWords];
    isaPkg::word_t    dmem [`DMEM_WORDS];
    isaPkg::word_t    pcIdx;

    // expected register writes and stores in program order
    isaPkg::regAddr_t expWbRd [$];
    isaPkg::word_t    expWbVal [$];
    isaPkg::word_t    expStAddr [$];
    isaPkg::word_t    expStData [$];

    int               progCount = 0;
    int               cycleLimit = 0;
    int               cycleCount = 0;
    int               runCycle = 0;    // cycles since reset release
    int               wbCount = 0;
    int               stCount = 0;
    isaPkg::word_t    expPc = `RESET_PC;
    logic [31:0]      rng;

`include "tbModel.svh"

    cpuCore u_dut (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .aluResult (aluResult),
        .writeData (writeData),
        .memWrite  (memWrite),
        .wbEn      (wbEn),
        .wbRd      (wbRd),
        .wbResult  (wbResult)
    );

    always #10 clk = ~clk;

    assign pcIdx = (pc - `RESET_PC) >> 2;
    assign instr = (pcIdx < imemWords) ? imem[pcIdx[7:0]] : '0;   // zeros past the program

    // 64 words indexed by address bits 7:2
    assign readData = dmem[aluResult[7:2]];

    always @(posedge clk) begin
        if (memWrite)
            dmem[aluResult[7:2]] <= writeData;
    end

    task automatic stopOnFail(string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic putInstr(isaPkg::word_t w);
        imem[progCount[7:0]] = w;
        progCount = progCount + 1;
    endtask

    task automatic buildProgram();
        isaPkg::regAddr_t rd, rs1, rs2, loadRd;
        logic [31:0]      r;
        logic [11:0]      imm, offs;
        logic [2:0]       f3, op;
        logic [3:0]       kind;
        for (int k = 0; k < imemWords; k++)
            imem[k[7:0]] = '0;
        // directed forwarding, load and x0 cases
        putInstr(encI(12'd5, 5'd0, 3'b000, 5'd1, isaPkg::opOpImm));    // addi x1, x0, 5
        putInstr(encI(12'hffd, 5'd1, 3'b000, 5'd2, isaPkg::opOpImm));  // x1 from mem stage
        putInstr(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));               // x1 wb, x2 mem
        putInstr(encR(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));               // x1 three back
        putInstr(encR(7'h00, 5'd2, 5'd4, 3'b010, 5'd6));               // slt
        putInstr(encI(12'h7a5, 5'd6, 3'b110, 5'd7, isaPkg::opOpImm));
        putInstr(encI(12'h0f3, 5'd7, 3'b111, 5'd8, isaPkg::opOpImm));
        putInstr(encS(12'd16, 5'd8, 5'd0));                            // sw x8, 16(x0)
        putInstr(encI(12'd16, 5'd0, 3'b010, 5'd9, isaPkg::opLoad));
        putInstr(encI(12'hfff, 5'd0, 3'b000, 5'd10, isaPkg::opOpImm));
        putInstr(encR(7'h00, 5'd10, 5'd9, 3'b000, 5'd11));             // load two back
        putInstr(encI(12'd123, 5'd0, 3'b000, 5'd0, isaPkg::opOpImm));  // writes to x0
        putInstr(encR(7'h00, 5'd11, 5'd11, 3'b000, 5'd0));
        putInstr(encR(7'h00, 5'd11, 5'd0, 3'b000, 5'd12));             // x0 must read zero
        putInstr(encR(7'h00, 5'd0, 5'd10, 3'b010, 5'd13));             // -1 < 0 signed
        putInstr(encS(12'd20, 5'd11, 5'd0));
        putInstr(encI(12'd20, 5'd0, 3'b010, 5'd5, isaPkg::opLoad));
        putInstr(encR(7'h20, 5'd1, 5'd0, 3'b000, 5'd6));
        putInstr(encR(7'h00, 5'd6, 5'd5, 3'b110, 5'd7));
        rng = 32'hcd1d948b;
        loadRd = 5'd0;
        for (int k = 0; k < numRandom; k++) begin
            rng  = xorshift32(rng);
            r    = rng;
            rng  = xorshift32(rng);
            rd   = isaPkg::regAddr_t'(r[7:0] % 8'd12);
            rs1  = isaPkg::regAddr_t'(r[15:8] % 8'd12);
            rs2  = isaPkg::regAddr_t'(r[23:16] % 8'd12);
            kind = r[31:28];
            op   = r[26:24] % 3'd5;
            imm  = rng[11:0];
            offs = {4'b0000, rng[17:12], 2'b00};
            // next instruction must not read a load result
            if (loadRd != 5'd0 && rs1 == loadRd)
                rs1 = rs1 ^ 5'd1;
            if (loadRd != 5'd0 && rs2 == loadRd)
                rs2 = rs2 ^ 5'd1;
            loadRd = 5'd0;
            if (kind < 4'd6) begin
                case (op)
                    3'd0, 3'd1: f3 = 3'b000;
                    3'd2:       f3 = 3'b111;
                    3'd3:       f3 = 3'b110;
                    default:    f3 = 3'b010;
                endcase
                putInstr(encR((op == 3'd1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
            end else if (kind < 4'd11) begin
                case (r[25:24])
                    2'd0:    f3 = 3'b000;
                    2'd1:    f3 = 3'b111;
                    2'd2:    f3 = 3'b110;
                    default: f3 = 3'b010;
                endcase
                putInstr(encI(imm, rs1, f3, rd, isaPkg::opOpImm));
            end else if (kind < 4'd13) begin
                putInstr(encI(offs, 5'd0, 3'b010, rd, isaPkg::opLoad));
                loadRd = rd;
            end else begin
                putInstr(encS(offs, rs2, 5'd0));
            end
        end
    endtask

    task automatic checkPc(isaPkg::word_t got, isaPkg::word_t exp);
        if (got !== exp) begin
            $display("error @%0t: pc expected %h, got %h", $time, exp, got);
            stopOnFail("program counter mismatch");
        end
    endtask

    task automatic checkLow(logic got, string name);
        if (got !== 1'b0) begin
            $display("error @%0t: %s high in cycle %0d after reset", $time, name, runCycle);
            stopOnFail("control output active too early");
        end
    endtask

    task automatic checkWb(isaPkg::regAddr_t gotRd, isaPkg::word_t gotVal);
        if (wbCount >= expWbRd.size()) begin
            stopOnFail($sformatf("register write to x%0d after the last expected one", gotRd));
        end else if (gotRd !== expWbRd[wbCount] || gotVal !== expWbVal[wbCount]) begin
            $display("error @%0t: write %0d expected x%0d = %h, got x%0d = %h", $time,
                     wbCount, expWbRd[wbCount], expWbVal[wbCount], gotRd, gotVal);
            stopOnFail("register write mismatch");
        end
    endtask

    task automatic checkStore(isaPkg::word_t gotAddr, isaPkg::word_t gotData);
        if (stCount >= expStAddr.size()) begin
            stopOnFail($sformatf("store to %h after the last expected one", gotAddr));
        end else if (gotAddr !== expStAddr[stCount] || gotData !== expStData[stCount]) begin
            $display("error @%0t: store %0d expected [%h] = %h, got [%h] = %h", $time,
                     stCount, expStAddr[stCount], expStData[stCount], gotAddr, gotData);
            stopOnFail("store mismatch");
        end
    endtask

    // outputs sampled at the edge that ends their cycle
    always @(posedge clk) begin
        if (!rst) begin
            checkPc(pc, expPc);
            if (runCycle < 3)
                checkLow(memWrite, "memWrite");
            if (runCycle < 4)
                checkLow(wbEn, "wbEn");
            if (wbEn) begin
                checkWb(wbRd, wbResult);
                wbCount <= wbCount + 1;
            end
            if (memWrite) begin
                checkStore(aluResult, writeData);
                stCount <= stCount + 1;
            end
            expPc    <= expPc + 32'd4;
            runCycle <= runCycle + 1;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, %0d of %0d writes and %0d of %0d stores seen",
                     cycleCount, wbCount, expWbRd.size(), stCount, expStAddr.size());
            stopOnFail("simulation did not finish within the cycle limit");
        end
    end

    initial begin
        rst <= 1'b1;
        for (int k = 0; k < `DMEM_WORDS; k++)
            dmem[k[5:0]] <= fillWord(k);
        buildProgram();
        runModel();
        cycleLimit = progCount + 10 + 20;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // last writeback lands 4 cycles after the last fetch, then a few spare
        while (runCycle < progCount + 8)
            @(posedge clk);
        if (wbCount != expWbRd.size() || stCount != expStAddr.size()) begin
            $display("saw %0d of %0d register writes and %0d of %0d stores",
                     wbCount, expWbRd.size(), stCount, expStAddr.size());
            stopOnFail("write or store count differs from the program");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule : tbCpu
